// File: rtl/life_pkg.sv
// life display shared definitions
// raster geometry, pipeline depth, seed constants and common types
// used by the display core and by the testbench reference model

`default_nettype none

package life_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // raster geometry
    ////////////////////////////////////////////////////////////////////////////

    // 400 x 512 clocks per frame, 204800 clocks at 12.288 MHz
    localparam int H_TOTAL  = 400;
    localparam int H_ACTIVE = 320;
    localparam int H_BPORCH = 10;
    localparam int V_TOTAL  = 512;
    localparam int V_ACTIVE = 240;
    localparam int V_BPORCH = 10;

    // line strobe a few clocks into the line, clear of the frame strobe
    localparam int HS_POS = 3;

    ////////////////////////////////////////////////////////////////////////////
    // cell source and pipeline
    ////////////////////////////////////////////////////////////////////////////

    localparam int LFSR_WIDTH = 31;

    // any nonzero state will do, all-zero locks the lfsr
    localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 31'h2B5E_3C71;

    // window register, rule register, video register
    localparam int PIPE_DEPTH = 3;

    // raster coordinate, wide enough for 0..511
    typedef logic [9:0] coord_t;

    // packed pixel, red in the top byte
    typedef logic [23:0] rgb_t;

endpackage

`default_nettype wire

// File: rtl/seed_lfsr.sv
// random cell source
// 31-bit fibonacci lfsr, taps x^31 + x^28 + 1
// one new cell per enabled clock on cell_in

`timescale 1ns/1ps
`default_nettype none

module seed_lfsr #(
    parameter logic [life_pkg::LFSR_WIDTH-1:0] LFSR_SEED = life_pkg::LFSR_SEED
) (
    input  logic clk_core_12288,
    input  logic reset_n,
    input  logic step_en,
    output logic cell_in
);

    import life_pkg::*;

    logic [LFSR_WIDTH-1:0] state;
    logic                  feedback;

    // taps at bit 31 and bit 28, numbered from one
    assign feedback = state[30] ^ state[27];

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            state <= LFSR_SEED;
        end else if (step_en) begin
            state <= {state[LFSR_WIDTH-2:0], feedback};
        end
    end

    // stream bit k is bit 0 after k steps
    assign cell_in = state[0];

endmodule

`default_nettype wire

// File: rtl/raster_timing.sv
// raster timing generator
// wrapping pixel and line counters, frame and line strobes,
// visible area decode and the sticky step enable for the life pipeline

`timescale 1ns/1ps
`default_nettype none

module raster_timing #(
    parameter int H_TOTAL  = life_pkg::H_TOTAL,
    parameter int V_TOTAL  = life_pkg::V_TOTAL,
    parameter int H_ACTIVE = life_pkg::H_ACTIVE,
    parameter int V_ACTIVE = life_pkg::V_ACTIVE,
    parameter int H_BPORCH = life_pkg::H_BPORCH,
    parameter int V_BPORCH = life_pkg::V_BPORCH,
    parameter int HS_POS   = life_pkg::HS_POS
) (
    input  logic             clk_core_12288,
    input  logic             reset_n,
    output life_pkg::coord_t x,
    output life_pkg::coord_t y,
    output logic             frame_start,
    output logic             line_start,
    output logic             active,
    output logic             step_en
);

    import life_pkg::*;

    logic x_last;
    logic y_last;
    logic h_visible;
    logic v_visible;

    ////////////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////////////

    assign x_last = (x == coord_t'(H_TOTAL - 1));
    assign y_last = (y == coord_t'(V_TOTAL - 1));

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            x <= '0;
            y <= '0;
        end else if (x_last) begin
            x <= '0;
            // line counter wraps with the pixel counter on the frame's last clock
            y <= y_last ? '0 : y + 1'b1;
        end else begin
            x <= x + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobes and visible area
    ////////////////////////////////////////////////////////////////////////////

    // top-left corner of the total frame
    assign frame_start = (x == '0) && (y == '0);

    // once per line, a few clocks after the frame strobe
    assign line_start = (x == coord_t'(HS_POS));

    assign h_visible = (x >= coord_t'(H_BPORCH)) && (x < coord_t'(H_BPORCH + H_ACTIVE));
    assign v_visible = (y >= coord_t'(V_BPORCH)) && (y < coord_t'(V_BPORCH + V_ACTIVE));
    assign active    = h_visible && v_visible;

    // step enable
    // held off until the first frame so the stream lines up with the raster
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            step_en <= 1'b0;
        end else if (frame_start) begin
            step_en <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/line_delay.sv
// one-bit line delay
// shift register of LENGTH cells that advances on step_en,
// used to hold one raster line of the life cell stream

`timescale 1ns/1ps
`default_nettype none

module line_delay #(
    parameter int LENGTH = life_pkg::H_TOTAL - 2
) (
    input  logic clk_core_12288,
    input  logic reset_n,
    input  logic step_en,
    input  logic d,
    output logic q
);

    // cell 0 is the newest, cell LENGTH-1 the oldest
    logic [LENGTH-1:0] cells;

    ////////////////////////////////////////////////////////////////////////////
    // shift line
    ////////////////////////////////////////////////////////////////////////////

    // cleared so the rows above the first stream line read as dead
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            cells <= '0;
        end else if (step_en) begin
            cells <= {cells[LENGTH-2:0], d};
        end
    end

    // oldest cell leaves the line
    assign q = cells[LENGTH-1];

endmodule

`default_nettype wire

// File: rtl/life_window.sv
// life neighbourhood window
// three 3-cell rows joined by two line delays give a 3x3 window
// with a row pitch of ROW_LEN, the life rule result is registered

`timescale 1ns/1ps
`default_nettype none

module life_window #(
    parameter int ROW_LEN = life_pkg::H_TOTAL
) (
    input  logic clk_core_12288,
    input  logic reset_n,
    input  logic step_en,
    input  logic cell_in,
    output logic cell_next
);

    // bit 0 of each row is its newest cell
    logic [2:0] row_new;
    logic [2:0] row_mid;
    logic [2:0] row_old;

    logic       mid_tap;
    logic       old_tap;
    logic [3:0] neighbours;
    logic       centre;
    logic       rule_alive;

    ////////////////////////////////////////////////////////////////////////////
    // line delays
    ////////////////////////////////////////////////////////////////////////////

    // taken from the middle cell of the row below
    // delay plus the row register above spans exactly ROW_LEN steps
    line_delay #(
        .LENGTH (ROW_LEN - 2)
    ) row_mid_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .step_en        (step_en),
        .d              (row_new[1]),
        .q              (mid_tap)
    );

    line_delay #(
        .LENGTH (ROW_LEN - 2)
    ) row_old_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .step_en        (step_en),
        .d              (row_mid[1]),
        .q              (old_tap)
    );

    ////////////////////////////////////////////////////////////////////////////
    // window rows
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            row_new <= '0;
            row_mid <= '0;
            row_old <= '0;
        end else if (step_en) begin
            row_new <= {row_new[1:0], cell_in};
            row_mid <= {row_mid[1:0], mid_tap};
            row_old <= {row_old[1:0], old_tap};
        end
    end

    // rule
    // centre is the middle of the middle row, the other eight are neighbours
    assign centre     = row_mid[1];
    assign neighbours = 4'($countones({row_new, row_mid[2], row_mid[0], row_old}));

    // birth on three, survival on two or three
    assign rule_alive = (neighbours == 4'd3) || ((neighbours == 4'd2) && centre);

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            cell_next <= 1'b0;
        end else begin
            cell_next <= rule_alive;
        end
    end

endmodule

`default_nettype wire

// File: rtl/video_out.sv
// video output stage
// registers sync strobes and data enable, expands the life cell
// to full-scale grey inside the visible area, black elsewhere

`timescale 1ns/1ps
`default_nettype none

module video_out (
    input  logic           clk_core_12288,
    input  logic           reset_n,
    input  logic           frame_start,
    input  logic           line_start,
    input  logic           active,
    input  logic           cell_next,
    output life_pkg::rgb_t video_rgb,
    output logic           video_de,
    output logic           video_hs,
    output logic           video_vs
);

    // one grey level per channel
    logic [7:0] grey;

    // white for a live cell, nothing outside the visible area
    assign grey = {8{cell_next & active}};

    ////////////////////////////////////////////////////////////////////////////
    // output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            video_vs <= 1'b0;
            video_hs <= 1'b0;
            video_de <= 1'b0;
        end else begin
            // single-clock strobes, a clock behind the raster counters
            video_vs <= frame_start;
            video_hs <= line_start;
            video_de <= active;
        end
    end

    // pixel data
    // same grey on red, green and blue
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
        end else begin
            video_rgb <= {grey, grey, grey};
        end
    end

endmodule

`default_nettype wire

// File: rtl/life_top.sv
// game of life display core top level
// raster timing and the lfsr cell stream feed the life window,
// whose result goes out as a 320x240 monochrome picture

`timescale 1ns/1ps
`default_nettype none

module life_top #(
    parameter int                              H_TOTAL   = life_pkg::H_TOTAL,
    parameter int                              V_TOTAL   = life_pkg::V_TOTAL,
    parameter int                              H_ACTIVE  = life_pkg::H_ACTIVE,
    parameter int                              V_ACTIVE  = life_pkg::V_ACTIVE,
    parameter int                              H_BPORCH  = life_pkg::H_BPORCH,
    parameter int                              V_BPORCH  = life_pkg::V_BPORCH,
    parameter int                              HS_POS    = life_pkg::HS_POS,
    parameter logic [life_pkg::LFSR_WIDTH-1:0] LFSR_SEED = life_pkg::LFSR_SEED
) (
    input  logic           clk_core_12288,
    input  logic           reset_n,
    output life_pkg::rgb_t video_rgb,
    output logic           video_de,
    output logic           video_hs,
    output logic           video_vs
);

    logic frame_start;
    logic line_start;
    logic active;
    logic step_en;
    logic cell_in;
    logic cell_next;

    ////////////////////////////////////////////////////////////////////////////
    // input side with raster and cell stream
    ////////////////////////////////////////////////////////////////////////////

    // raster position is only used inside the timing block
    raster_timing #(
        .H_TOTAL  (H_TOTAL),
        .V_TOTAL  (V_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .H_BPORCH (H_BPORCH),
        .V_BPORCH (V_BPORCH),
        .HS_POS   (HS_POS)
    ) raster_timing_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .x              (),
        .y              (),
        .frame_start    (frame_start),
        .line_start     (line_start),
        .active         (active),
        .step_en        (step_en)
    );

    seed_lfsr #(
        .LFSR_SEED (LFSR_SEED)
    ) seed_lfsr_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .step_en        (step_en),
        .cell_in        (cell_in)
    );

    // processing
    // row pitch of the window is one full raster line
    life_window #(
        .ROW_LEN (H_TOTAL)
    ) life_window_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .step_en        (step_en),
        .cell_in        (cell_in),
        .cell_next      (cell_next)
    );

    // output side
    video_out video_out_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .frame_start    (frame_start),
        .line_start     (line_start),
        .active         (active),
        .cell_next      (cell_next),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// testbench clock and reset source
// free-running core clock, active-low reset held for a fixed cycle count

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_core_12288,
    output logic reset_n
);

    // core clock, first rising edge half a period in
    initial begin
        clk_core_12288 = 1'b0;
        forever #(PERIOD_NS / 2) clk_core_12288 = ~clk_core_12288;
    end

    // reset changes only on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_core_12288);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/life_tb.sv
// game of life display core testbench
// runs two frames from reset and checks sync strobes, data enable,
// blanking and the pixel stream against a reference life model

`timescale 1ns/1ps
`default_nettype none

module life_tb;

    import life_pkg::*;

    localparam int          FRAME_CLOCKS  = H_TOTAL * V_TOTAL;
    localparam int          RUN_CLOCKS    = 2 * FRAME_CLOCKS;
    localparam int          HIST_LEN      = 2 * H_TOTAL + 3;
    localparam int          RESET_TIMEOUT = 100;
    localparam int          RANDOM_LINES  = 12;
    localparam int unsigned RAND_SEED     = 32'h8ce49e40;

    logic clk_core_12288;
    logic reset_n;
    rgb_t video_rgb;
    logic video_de;
    logic video_hs;
    logic video_vs;

    // output index, 0 on the first clock with video_vs high
    int   clk_index = -1;
    bit   checks_done = 1'b0;
    int   error_count = 0;
    bit   sampled_line [2 * V_TOTAL];

    // sync and data enable bookkeeping
    int   vs_count = 0;
    int   hs_count = 0;
    int   last_vs = 0;
    int   last_hs = 0;
    int   de_run = 0;
    int   de_lines = 0;
    logic prev_de = 1'b0;

    // reference model, own lfsr and the last HIST_LEN stream bits
    logic [LFSR_WIDTH-1:0] model_state = LFSR_SEED;
    logic [HIST_LEN-1:0]   model_hist  = '0;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (16)
    ) tb_clock_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n)
    );

    life_top life_top_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // one call per output index, in order
    // hist[0] is stream bit j = k - PIPE_DEPTH, hist[d] is bit j - d
    function automatic rgb_t expected_rgb(input int k, input logic de);
        int   count;
        int   r;
        int   c;
        logic centre;
        logic alive;

        // bits below index 0 stay dead in the cleared history
        if (k >= PIPE_DEPTH) begin
            model_hist  = {model_hist[HIST_LEN-2:0], model_state[0]};
            // x^31 + x^28 + 1, state bits 30 and 27
            model_state = {model_state[LFSR_WIDTH-2:0], model_state[30] ^ model_state[27]};
        end
        count = 0;
        for (r = 0; r < 3; r++) begin
            for (c = 0; c < 3; c++) begin
                if ((r != 1 || c != 1) && model_hist[r * H_TOTAL + c]) begin
                    count++;
                end
            end
        end
        centre = model_hist[H_TOTAL + 1];
        // birth on three, survival on two
        alive = (count == 3) || ((count == 2) && centre);
        return (alive && de) ? {24{1'b1}} : '0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare and failure tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT: %s", what);
        abort_run();
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s at index %0d: expected %h, actual %h",
                     name, clk_index, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s at index %0d: expected %b, actual %b",
                     name, clk_index, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("CHECK FAILED %s at index %0d: expected %0d, actual %0d",
                     name, clk_index, expected, actual);
            abort_run();
        end
    endtask

    // index advances on the rising edge, read on the falling edge
    always @(posedge clk_core_12288) begin
        if (!reset_n) begin
            clk_index <= -1;
        end else begin
            clk_index <= clk_index + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output comparison, mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_core_12288) begin : compare_outputs
        int   k;
        int   q;
        int   xa;
        int   ya;
        logic exp_vs;
        logic exp_hs;
        logic exp_de;
        rgb_t exp_rgb;

        k = clk_index;
        if (k < 0) begin
            // reset and the clocks before the first frame strobe
            check_bit("reset_vs", 1'b0, video_vs);
            check_bit("reset_hs", 1'b0, video_hs);
            check_bit("reset_de", 1'b0, video_de);
            check_rgb("reset_rgb", '0, video_rgb);
        end else if (k < RUN_CLOCKS) begin
            // outputs at index k come from raster position k of the frame
            q  = k % FRAME_CLOCKS;
            xa = q % H_TOTAL;
            ya = q / H_TOTAL;
            exp_vs = (q == 0);
            exp_hs = (xa == HS_POS);
            exp_de = (xa >= H_BPORCH) && (xa < H_BPORCH + H_ACTIVE)
                  && (ya >= V_BPORCH) && (ya < V_BPORCH + V_ACTIVE);
            exp_rgb = expected_rgb(k, exp_de);

            check_bit("vs_timing", exp_vs, video_vs);
            check_bit("hs_timing", exp_hs, video_hs);
            check_bit("de_timing", exp_de, video_de);
            if (video_de !== 1'b1) begin
                check_rgb("blank_rgb", '0, video_rgb);
            end
            if (sampled_line[(k / FRAME_CLOCKS) * V_TOTAL + ya]) begin
                check_rgb("pixel_rgb", exp_rgb, video_rgb);
            end

            // strobe periods
            if (video_vs === 1'b1) begin
                if (vs_count > 0) begin
                    check_count("vs_period", FRAME_CLOCKS, k - last_vs);
                end
                last_vs = k;
                vs_count++;
            end
            if (video_hs === 1'b1) begin
                if (hs_count > 0) begin
                    check_count("hs_period", H_TOTAL, k - last_hs);
                end
                last_hs = k;
                hs_count++;
            end

            // de runs, counted from the clock the pixel counter restarts
            if (video_de === 1'b1) begin
                if (!prev_de) begin
                    check_count("de_start", H_BPORCH + 1, (k + 1) % H_TOTAL);
                end
                de_run++;
            end else if (prev_de) begin
                check_count("de_run", H_ACTIVE, de_run);
                de_run = 0;
                de_lines++;
            end
            prev_de = video_de;
            if (q == FRAME_CLOCKS - 1) begin
                check_count("de_lines", V_ACTIVE, de_lines);
                de_lines = 0;
            end
        end else if (!checks_done) begin
            check_count("vs_count", 2, vs_count);
            check_count("hs_count", 2 * V_TOTAL, hs_count);
            checks_done = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////////////////////

    initial begin : run_control
        int i;
        int line_no;
        int waited;

        void'($urandom(RAND_SEED));
        for (i = 0; i < 2 * V_TOTAL; i++) begin
            sampled_line[i] = 1'b0;
        end
        // first 20 visible lines of frame one
        for (i = 0; i < 20; i++) begin
            sampled_line[V_BPORCH + i] = 1'b1;
        end
        // random visible lines in both frames
        for (i = 0; i < 2 * RANDOM_LINES; i++) begin
            line_no = V_BPORCH + int'($urandom_range(V_ACTIVE - 1));
            sampled_line[(i / RANDOM_LINES) * V_TOTAL + line_no] = 1'b1;
        end

        waited = 0;
        while (reset_n !== 1'b1) begin
            @(posedge clk_core_12288);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                report_timeout("reset_n was never released");
            end
        end

        waited = 0;
        while (!checks_done) begin
            @(negedge clk_core_12288);
            waited++;
            if (waited > RUN_CLOCKS + RESET_TIMEOUT) begin
                report_timeout("two frames of output did not complete");
            end
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "run ended with mismatches");
        end
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/life_pkg.sv
rtl/seed_lfsr.sv
rtl/raster_timing.sv
rtl/line_delay.sv
rtl/life_window.sv
rtl/video_out.sv
rtl/life_top.sv
tests/tb_clock.sv
tests/life_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the life display testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module life_tb \
    --Mdir obj_dir -o life_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/life_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
